//--- verilog/adpcm_pkg.sv
/* shared types, register map and decode tables for the ADPCM-A playback core.
   register data is 8 bits wide and at most MAX_CH channels are supported */
`default_nettype none

package adpcm_pkg;

    localparam int MAX_CH = 6;               // also width of the key mask

    // register map, 6-bit word addresses
    localparam logic [5:0] REG_KEY       = 6'd0;  // write only
    localparam logic [5:0] REG_STATUS    = 6'd1;  // end flags, write 1 to clear
    localparam logic [5:0] REG_CH_BASE   = 6'd8;
    localparam logic [5:0] REG_CH_STRIDE = 6'd4;
    localparam logic [5:0] REG_OFF_START = 6'd0;
    localparam logic [5:0] REG_OFF_END   = 6'd1;
    localparam logic [5:0] REG_OFF_CTRL  = 6'd2;

    typedef struct packed {
        logic       pan_l;
        logic       pan_r;
        logic [2:0] rsvd;
        logic [2:0] atten;                   // plain right shift, 0..7
    } ch_ctrl_t;

    typedef struct packed {
        logic              key_off;          // 0 = key-on, 1 = key-off
        logic              rsvd;
        logic [MAX_CH-1:0] ch_mask;
    } key_cmd_t;

    // one write data byte, meaning depends on the address
    typedef union packed {
        ch_ctrl_t ctrl;
        key_cmd_t key;
    } reg_word_u;

    typedef struct packed {
        logic [7:0] start_blk;               // 256-byte ROM blocks
        logic [7:0] end_blk;                 // inclusive
        ch_ctrl_t   ctrl;
    } ch_cfg_t;

    typedef struct packed {
        logic       valid;
        logic       first;                   // decoder restarts from zero
        logic [3:0] code;
    } nibble_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } ch_out_t;

    localparam logic [11:0] step_table [49] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // index step per magnitude; +8 needs the fifth bit
    localparam logic signed [4:0] index_adj [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd4, 5'sd6, 5'sd8
    };

endpackage

`default_nettype wire

//--- verilog/adpcm_regs.sv
/* Wishbone classic slave without stall or error; ack one cycle after strobe.
   only the status register reads back, every other address reads zero */
`timescale 1ns/1ps
`default_nettype none

module adpcm_regs import adpcm_pkg::*; #(
    parameter int NUM_CH = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   wb_cyc,
    input  wire logic                   wb_stb,
    input  wire logic                   wb_we,
    input  wire logic [5:0]             wb_adr,
    input  wire logic [7:0]             wb_dat_w,
    output logic      [7:0]             wb_dat_r,
    output logic                        wb_ack,
    output ch_cfg_t   [NUM_CH-1:0]      cfg,
    output logic      [NUM_CH-1:0]      key_on,
    output logic      [NUM_CH-1:0]      key_off,
    input  wire logic [NUM_CH-1:0]      end_hit
);

    logic              acc;                 // first cycle of an access
    logic              wr;
    logic              rd;
    logic              in_ch;
    logic [5:0]        ch_off;
    logic [5:0]        ch_sel;
    logic [5:0]        reg_off;
    logic [NUM_CH-1:0] end_flags;          // sticky
    logic [NUM_CH-1:0] clr;
    reg_word_u         wd;

    assign acc = wb_cyc & wb_stb & ~wb_ack;  // ~ack keeps back-to-back apart
    assign wr  = acc & wb_we;
    assign rd  = acc & ~wb_we;
    assign wd  = wb_dat_w;

    // channel window decode
    assign in_ch   = wb_adr >= REG_CH_BASE;
    assign ch_off  = wb_adr - REG_CH_BASE;
    assign ch_sel  = ch_off / REG_CH_STRIDE;
    assign reg_off = ch_off % REG_CH_STRIDE;

    assign clr = (wr && wb_adr == REG_STATUS) ? wb_dat_w[NUM_CH-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            key_on    <= '0;
            key_off   <= '0;
            end_flags <= '0;
            cfg       <= '0;
        end else begin
            wb_ack   <= acc;
            wb_dat_r <= (rd && wb_adr == REG_STATUS) ? 8'(end_flags) : 8'h00;

            // key command gives one-cycle pulses per masked channel
            key_on  <= '0;
            key_off <= '0;
            if (wr && wb_adr == REG_KEY) begin
                if (wd.key.key_off) key_off <= wd.key.ch_mask[NUM_CH-1:0];
                else                key_on  <= wd.key.ch_mask[NUM_CH-1:0];
            end

            end_flags <= (end_flags & ~clr) | end_hit;  // new hit beats clear

            for (int i = 0; i < NUM_CH; i++) begin
                if (wr && in_ch && ch_sel == 6'(i)) begin
                    case (reg_off)
                        REG_OFF_START: cfg[i].start_blk <= wb_dat_w;
                        REG_OFF_END:   cfg[i].end_blk   <= wb_dat_w;
                        REG_OFF_CTRL:  cfg[i].ctrl      <= wd.ctrl;
                        default: ;                      // hole in the map
                    endcase
                end
            end
        end
    end

    // host keeps the strobe up until the ack
    a_host_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && wb_stb));

    // key pulses never last two cycles
    a_key_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        |(key_on | key_off) |=> !(|(key_on | key_off)));

endmodule

`default_nettype wire

//--- verilog/adpcm_fetch.sv
/* ROM has fixed one-cycle read latency; frame is 2*NUM_CH cycles.
   end_blk below start_blk wraps through the whole 64 KiB ROM */
`timescale 1ns/1ps
`default_nettype none

module adpcm_fetch import adpcm_pkg::*; #(
    parameter int NUM_CH = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire ch_cfg_t [NUM_CH-1:0]   cfg,
    input  wire logic    [NUM_CH-1:0]   key_on,
    input  wire logic    [NUM_CH-1:0]   key_off,
    output logic         [15:0]         rom_addr,
    output logic                        rom_rd,
    input  wire logic    [7:0]          rom_data,
    output nibble_t      [NUM_CH-1:0]   nib,
    output logic                        frame_end,
    output logic         [NUM_CH-1:0]   end_hit
);

    localparam int CHW = $clog2(MAX_CH);

    logic [CHW-1:0]    cur_ch;
    logic              phase;              // 0 = rom read, 1 = nibble out
    logic [NUM_CH-1:0] slot_sel;
    logic [NUM_CH-1:0] active;
    logic [NUM_CH-1:0] first_q;            // next nibble restarts decoder
    logic [NUM_CH-1:0] pend_on;            // key-on waiting for frame start
    logic [NUM_CH-1:0] nib_valid;
    logic [16:0]       addr_q [NUM_CH];    // nibble address with bit 0 for the low nibble
    logic [NUM_CH-1:0] last_nib;
    logic [NUM_CH-1:0] load;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            slot_sel[i] = cur_ch == CHW'(i);
            last_nib[i] = addr_q[i][0] && addr_q[i][16:1] == {cfg[i].end_blk, 8'hff};
            load[i]     = frame_end && (pend_on[i] || key_on[i]);
        end
    end

    assign frame_end = phase && cur_ch == CHW'(NUM_CH - 1);
    assign rom_rd    = ~phase && |(slot_sel & active);

    always_comb begin
        rom_addr = '0;
        for (int i = 0; i < NUM_CH; i++)
            if (slot_sel[i]) rom_addr = addr_q[i][16:1];
    end

    // nibble hand-off; an idle channel gets a clear so its output drops to zero
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            nib[i] = '0;
            if (slot_sel[i] && phase) begin
                nib[i].valid = active[i];
                nib[i].first = first_q[i] | ~active[i];
                if (active[i])
                    nib[i].code = addr_q[i][0] ? rom_data[3:0] : rom_data[7:4];
            end
            nib_valid[i] = nib[i].valid;
        end
    end

    // slot sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_ch <= '0;
            phase  <= 1'b0;
        end else if (phase) begin
            phase  <= 1'b0;
            cur_ch <= frame_end ? '0 : cur_ch + 1'b1;
        end else begin
            phase <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= '0;
            first_q <= '0;
            pend_on <= '0;
            end_hit <= '0;
        end else begin
            end_hit <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                if (nib_valid[i]) begin
                    first_q[i] <= 1'b0;
                    if (last_nib[i]) begin      // past end of block
                        active[i]  <= 1'b0;
                        end_hit[i] <= 1'b1;
                    end
                end
                if (load[i]) begin
                    active[i]  <= 1'b1;
                    first_q[i] <= 1'b1;
                    pend_on[i] <= 1'b0;
                end else if (key_on[i]) begin
                    pend_on[i] <= 1'b1;
                end
                if (key_off[i]) begin           // stop at once
                    active[i]  <= 1'b0;
                    pend_on[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CH; i++) begin
            if (load[i])
                addr_q[i] <= {cfg[i].start_blk, 9'd0};  // high nibble of block start
            else if (nib_valid[i] && !last_nib[i])
                addr_q[i] <= addr_q[i] + 17'd1;
        end
    end

    // a nibble only goes out on data that the rom was asked for
    a_nib_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        |nib_valid |-> $past(rom_rd));

endmodule

`default_nettype wire

//--- verilog/adpcm_channel.sv
/* one ADPCM-A decoder, 12-bit accumulator widened to 16 bits.
   output is held between nibbles; cfg changes apply at the next nibble */
`timescale 1ns/1ps
`default_nettype none

module adpcm_channel import adpcm_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire ch_cfg_t cfg,
    input  wire nibble_t nib,
    output ch_out_t      out
);

    logic signed [11:0] acc;
    logic        [5:0]  idx;               // 0..48
    logic signed [11:0] base_acc;
    logic        [5:0]  base_idx;
    logic        [2:0]  mag;
    logic        [11:0] step;
    logic        [15:0] prod;
    logic        [11:0] delta;
    logic signed [13:0] sum;
    logic signed [7:0]  idx_sum;
    logic signed [11:0] acc_next;
    logic        [5:0]  idx_next;
    logic signed [15:0] wide;
    logic signed [15:0] scaled;
    logic               upd;

    // a first nibble decodes from a cleared state
    assign base_acc = nib.first ? 12'sd0 : acc;
    assign base_idx = nib.first ? 6'd0 : idx;
    assign mag      = nib.code[2:0];
    assign step     = step_table[base_idx];

    // step * (2m+1) / 8
    assign prod  = 16'(step) * 16'({mag, 1'b1});
    assign delta = 12'(prod >> 3);

    assign sum = nib.code[3] ? 14'(base_acc) - $signed({2'b00, delta})
                             : 14'(base_acc) + $signed({2'b00, delta});

    assign idx_sum = $signed({2'b00, base_idx}) + 8'(index_adj[mag]);

    always_comb begin
        acc_next = acc;
        idx_next = idx;
        if (nib.valid) begin
            if (sum > 14'sd2047)        acc_next = 12'sd2047;   // clip high
            else if (sum < -14'sd2048)  acc_next = -12'sd2048;  // clip low
            else                        acc_next = sum[11:0];
            if (idx_sum < 8'sd0)        idx_next = 6'd0;
            else if (idx_sum > 8'sd48)  idx_next = 6'd48;
            else                        idx_next = idx_sum[5:0];
        end else if (nib.first) begin   // clear without a decode
            acc_next = 12'sd0;
            idx_next = 6'd0;
        end
    end

    assign upd = nib.valid | nib.first;

    // gain and pan
    assign wide   = $signed({acc_next, 4'h0});
    assign scaled = wide >>> cfg.ctrl.atten;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            idx <= '0;
            out <= '0;
        end else if (upd) begin
            acc       <= acc_next;
            idx       <= idx_next;
            out.left  <= cfg.ctrl.pan_l ? scaled : 16'sd0;
            out.right <= cfg.ctrl.pan_r ? scaled : 16'sd0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/adpcm_mixer.sv
/* stereo mix of all channels, saturated to 16 bits.
   one sample per frame; the last slot's nibble lands in the next frame */
`timescale 1ns/1ps
`default_nettype none

module adpcm_mixer import adpcm_pkg::*; #(
    parameter int NUM_CH = 4
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire ch_out_t [NUM_CH-1:0]     ch,
    input  wire logic                     frame_end,
    output logic signed  [15:0]           sample_l,
    output logic signed  [15:0]           sample_r,
    output logic                          sample_valid
);

    localparam int SW = 17 + $clog2(NUM_CH);   // headroom for the sum

    localparam logic signed [SW-1:0] POS_LIM = 32767;
    localparam logic signed [SW-1:0] NEG_LIM = -32768;

    logic signed [SW-1:0] sum_l;
    logic signed [SW-1:0] sum_r;

    function automatic logic signed [15:0] sat16(input logic signed [SW-1:0] v);
        if (v > POS_LIM) return 16'sh7fff;
        if (v < NEG_LIM) return -16'sh8000;
        return v[15:0];
    endfunction

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            sum_l = sum_l + SW'(ch[i].left);   // sign extended
            sum_r = sum_r + SW'(ch[i].right);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_l     <= '0;
            sample_r     <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= frame_end;
            if (frame_end) begin
                sample_l <= sat16(sum_l);
                sample_r <= sat16(sum_r);
            end
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

//--- verilog/adpcm_top.sv
/* ADPCM-A playback top, NUM_CH from 1 to MAX_CH.
   ROM must return data one cycle after rom_rd; host must hold until ack */
`timescale 1ns/1ps
`default_nettype none

module adpcm_top import adpcm_pkg::*; #(
    parameter int NUM_CH = 4
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         wb_cyc,
    input  wire logic         wb_stb,
    input  wire logic         wb_we,
    input  wire logic [5:0]   wb_adr,
    input  wire logic [7:0]   wb_dat_w,
    output logic      [7:0]   wb_dat_r,
    output logic              wb_ack,
    output logic      [15:0]  rom_addr,
    output logic              rom_rd,
    input  wire logic [7:0]   rom_data,
    output logic signed [15:0] sample_l,
    output logic signed [15:0] sample_r,
    output logic              sample_valid
);

    ch_cfg_t [NUM_CH-1:0] cfg;
    logic    [NUM_CH-1:0] key_on;
    logic    [NUM_CH-1:0] key_off;
    logic    [NUM_CH-1:0] end_hit;
    nibble_t [NUM_CH-1:0] nib;
    ch_out_t [NUM_CH-1:0] ch_out;
    logic                 frame_end;

    adpcm_regs #(.NUM_CH(NUM_CH)) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg),
        .key_on   (key_on),
        .key_off  (key_off),
        .end_hit  (end_hit)
    );

    adpcm_fetch #(.NUM_CH(NUM_CH)) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .key_on    (key_on),
        .key_off   (key_off),
        .rom_addr  (rom_addr),
        .rom_rd    (rom_rd),
        .rom_data  (rom_data),
        .nib       (nib),
        .frame_end (frame_end),
        .end_hit   (end_hit)
    );

    // one decoder per channel
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        adpcm_channel u_ch (
            .clk   (clk),
            .rst_n (rst_n),
            .cfg   (cfg[i]),
            .nib   (nib[i]),
            .out   (ch_out[i])
        );
    end

    adpcm_mixer #(.NUM_CH(NUM_CH)) u_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .ch           (ch_out),
        .frame_end    (frame_end),
        .sample_l     (sample_l),
        .sample_r     (sample_r),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

//--- test/adpcm_rom.sv
/* registered sample ROM, data one cycle after rd.
   blocks 1, 2 and 3 hold 0x77, 0xff and 0x00; the rest is address-derived */
`timescale 1ns/1ps
`default_nettype none

module adpcm_rom (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        rd,
    input  wire logic [15:0] addr,
    output logic      [7:0]  data
);

    // contents by 256-byte block
    function automatic logic [7:0] rom_byte(input logic [15:0] a);
        case (a[15:8])
            8'h01:   return 8'h77;          // large positive steps
            8'h02:   return 8'hff;          // large negative steps
            8'h03:   return 8'h00;
            default: return a[15:8] ^ a[7:0] ^ 8'h5a;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            data <= '0;
        else if (rd)
            data <= rom_byte(addr);         // one-cycle latency
    end

endmodule

`default_nettype wire

//--- test/adpcm_tb.sv
/* testbench for adpcm_top with 4 channels and the block-pattern ROM.
   checks run through assertions; channel 0 output is aligned on its start read */
`timescale 1ns/1ps
`default_nettype none

module adpcm_tb;

    // frames the tests wait through; 512 is one block read nibble by nibble
    localparam int     FRAMES   = 512 + 2 * 64 + 3 * 24 + 36 + 40 + 64;
    localparam int     FRAME_NS = 2 * 4 * 100;               // 4 slots of two cycles
    localparam longint LIMIT_NS = longint'(FRAMES) * FRAME_NS * 2;  // room for bus setup

    logic               clk;
    logic               rst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic        [5:0]  wb_adr;
    logic        [7:0]  wb_dat_w;
    logic        [7:0]  wb_dat_r;
    logic               wb_ack;
    logic        [15:0] rom_addr;
    logic               rom_rd;
    logic        [7:0]  rom_data;
    logic signed [15:0] sample_l;
    logic signed [15:0] sample_r;
    logic               sample_valid;

    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          collect;                 // log rom reads
    bit          check_range;             // only block 1 may be read
    logic [15:0] reads[$];
    int          ref_a[256];
    int          ref_b[256];

    const int step_tab[49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279,
        307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963,
        1060, 1166, 1282, 1411, 1552
    };
    const int idx_tab[8] = '{-1, -1, -1, -1, 2, 4, 6, 8};

    adpcm_top #(.NUM_CH(4)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .rom_addr(rom_addr), .rom_rd(rom_rd), .rom_data(rom_data),
        .sample_l(sample_l), .sample_r(sample_r), .sample_valid(sample_valid)
    );

    adpcm_rom rom0 (.clk(clk), .rst_n(rst_n), .rd(rom_rd), .addr(rom_addr), .data(rom_data));

    always #50 clk = ~clk;

    // bus protocol
    a_ack_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            $display("wb_ack missing one cycle after strobe at %0t", $time);
            errors++;
        end
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            $display("wb_ack held longer than one cycle at %0t", $time);
            errors++;
        end
    a_read_range: assert property (@(posedge clk) disable iff (!rst_n)
        (check_range && rom_rd) |-> rom_addr[15:8] == 8'h01)
        else begin
            $display("rom read outside block 1 at %0t", $time);
            errors++;
        end

    always @(negedge clk)
        if (collect && rom_rd) reads.push_back(rom_addr);

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp)
        else begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wb_access(input bit we, input logic [5:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < 4);
        check_val("wb_ack delay", n, 2);      // ack low on the first negedge and high on the second
        rdat = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [5:0] adr, input logic [7:0] d);
        logic [7:0] dummy;
        wb_access(1'b1, adr, d, dummy);
    endtask

    task automatic wb_read(input logic [5:0] adr, output logic [7:0] d);
        wb_access(1'b0, adr, 8'h00, d);
    endtask

    task automatic setup_channel(input int ch, input int sblk, input int eblk,
                                 input bit pl, input bit pr, input int at);
        wb_write(6'(8 + 4 * ch), 8'(sblk));
        wb_write(6'(9 + 4 * ch), 8'(eblk));
        wb_write(6'(10 + 4 * ch), {pl, pr, 3'b000, 3'(at)});
    endtask

    // wait from the next negedge on for a rom read of a given address
    task automatic wait_read(input logic [15:0] a);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(rom_rd && rom_addr == a) && n < 64);
        if (n >= 64) begin
            $display("no rom read of %h after key-on", a);
            errors++;
        end
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!sample_valid && n < 20);
        if (n >= 20) begin
            $display("sample_valid did not arrive within a frame");
            errors++;
        end
    endtask

    // reference decode of a block of one repeated nibble code
    task automatic build_ref(input bit second, input logic [3:0] code);
        int acc;
        int idx;
        int delta;
        acc = 0;
        idx = 0;
        for (int k = 0; k < 256; k++) begin
            delta = step_tab[idx] * (2 * int'(code[2:0]) + 1) / 8;
            acc   = code[3] ? acc - delta : acc + delta;
            if (acc > 2047) acc = 2047;
            if (acc < -2048) acc = -2048;
            idx = idx + idx_tab[code[2:0]];
            if (idx < 0) idx = 0;
            if (idx > 48) idx = 48;
            if (second) ref_b[k] = acc;
            else ref_a[k] = acc;
        end
    endtask

    function automatic int sat16(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    function automatic int shaped(input int acc, input bit en, input int at);
        int w;
        w = acc * 16;
        return en ? (w >>> at) : 0;
    endfunction

    // compare n samples; ch1 adds ref_b when two is set
    task automatic check_samples(input int first, input int n, input bit two,
                                 input bit pl, input bit pr, input int at);
        int el;
        int er;
        for (int k = first; k < first + n; k++) begin
            wait_sample();
            el = shaped(ref_a[k], pl, at) + (two ? shaped(ref_b[k], pl, at) : 0);
            er = shaped(ref_a[k], pr, at) + (two ? shaped(ref_b[k], pr, at) : 0);
            check_val("sample_l", sample_l, sat16(el));
            check_val("sample_r", sample_r, sat16(er));
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, errors == err_before ? "ok" : "errors");
    endtask

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired, run took longer than the tests allow");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [7:0] d;
        int         e0;
        bit         pl;
        bit         pr;
        int         at;
        clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        collect = 1'b0;
        check_range = 1'b0;
        void'($urandom(32'h7f2a));
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        e0 = errors;                          // bus and status after reset
        wb_read(6'd1, d);
        check_val("status", d, 0);
        end_test("wishbone", e0);

        e0 = errors;                          // channel 0 over block 1 only
        setup_channel(0, 1, 1, 1'b1, 1'b0, 0);
        collect = 1'b1;
        check_range = 1'b1;
        wb_write(6'd0, 8'h01);
        for (int n = 0; n < 8000 && reads.size() < 512; n++) @(negedge clk);
        repeat (32) @(negedge clk);
        check_val("read count", reads.size(), 512);
        foreach (reads[k]) check_val("rom_addr", reads[k], 16'h0100 + k / 2);
        collect = 1'b0;
        check_range = 1'b0;
        wb_read(6'd1, d);
        check_val("status", d, 1);
        wb_write(6'd1, 8'h01);                // write-1 clear
        wb_read(6'd1, d);
        check_val("status", d, 0);
        end_test("address range", e0);

        e0 = errors;                          // plain decode on the left only
        build_ref(1'b0, 4'h7);
        setup_channel(0, 1, 3, 1'b1, 1'b0, 0);
        wb_write(6'd0, 8'h01);
        wait_read(16'h0100);
        check_samples(0, 64, 1'b0, 1'b1, 1'b0, 0);
        build_ref(1'b0, 4'hf);
        wb_write(6'd8, 8'd2);
        wb_write(6'd0, 8'h01);                // restart on block 2
        wait_read(16'h0200);
        check_samples(0, 64, 1'b0, 1'b1, 1'b0, 0);
        end_test("decode", e0);

        e0 = errors;                          // random gain and pan
        build_ref(1'b0, 4'h7);
        for (int r = 0; r < 3; r++) begin
            pl = 1'($urandom);
            pr = 1'($urandom);
            at = $urandom % 8;
            setup_channel(0, 1, 3, pl, pr, at);
            wb_write(6'd0, 8'h01);
            wait_read(16'h0100);
            check_samples(0, 24, 1'b0, pl, pr, at);
        end
        end_test("atten and pan", e0);

        e0 = errors;                          // opposite blocks cancel
        build_ref(1'b1, 4'hf);
        setup_channel(0, 1, 3, 1'b1, 1'b1, 1);
        setup_channel(1, 2, 3, 1'b1, 1'b1, 1);
        wb_write(6'd0, 8'h03);
        wait_read(16'h0100);
        check_samples(0, 32, 1'b1, 1'b1, 1'b1, 1);
        wb_write(6'd0, 8'h83);                // key-off both
        wait_sample();                        // may still hold old output
        for (int k = 0; k < 3; k++) begin
            wait_sample();
            check_val("sample_l", sample_l, 0);
            check_val("sample_r", sample_r, 0);
        end
        end_test("mixing", e0);

        e0 = errors;                          // key-on while playing
        setup_channel(0, 1, 3, 1'b1, 1'b0, 0);
        wb_write(6'd0, 8'h01);
        wait_read(16'h0100);
        check_samples(0, 40, 1'b0, 1'b1, 1'b0, 0);
        wb_write(6'd0, 8'h01);
        wait_read(16'h0100);
        check_samples(0, 64, 1'b0, 1'b1, 1'b0, 0);
        end_test("key restart", e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/adpcm_pkg.sv
verilog/adpcm_regs.sv
verilog/adpcm_fetch.sv
verilog/adpcm_channel.sv
verilog/adpcm_mixer.sv
verilog/adpcm_top.sv
test/adpcm_rom.sv
test/adpcm_tb.sv

//--- Makefile
# Verilator build for the ADPCM-A playback testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module adpcm_tb -f all.f

obj_dir/Vadpcm_tb: all.f
	verilator --binary --timing --assert --top-module adpcm_tb -f all.f

sim: obj_dir/Vadpcm_tb
	./obj_dir/Vadpcm_tb | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
